// ==== common/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Buffer geometry, entry count must stay a power of two
`define ROB_NUM_ENTS 8
`define ROB_IDX_W 3

// Source lookups per allocation
`define ROB_NUM_SRCS 2

// Architectural and physical register address widths
`define GPR_W 5
`define PRF_W 6

// Quiet time between the nuke pulse and the start of the restore walk
`define ROB_QUIESCE_CYCLES 5

`endif

// ==== common/rob_pkg.sv ====
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

   // Wrap bit plus slot index
   // Same index with different wrap bits means the buffer is full
   typedef struct packed {
      logic                  wrap;
      logic [`ROB_IDX_W-1:0] idx;
   } t_rob_id;

   typedef struct packed {
      logic              dst_valid;
      logic [`GPR_W-1:0] dst_reg;
      logic              is_branch;
      logic [7:0]        tag;
   } t_uinstr;

   typedef struct packed {
      logic    valid;
      t_rob_id robid;
      logic    flush_needed;
      logic    mispred;
   } t_rob_complete_pkt;

   // Written once at allocation
   typedef struct packed {
      t_uinstr           uinstr;
      logic [`PRF_W-1:0] pdst_old;
   } t_rob_ent_static;

   typedef struct packed {
      logic            valid;
      logic            ready;
      logic            flush_needed;
      logic            mispred;
      t_rob_ent_static st;
   } t_rob_ent;

   typedef enum logic {
      NUKE_BR_MISPRED,
      NUKE_EXCEPTION
   } t_nuke_type;

   typedef struct packed {
      logic       valid;
      t_nuke_type nuke_type;
   } t_nuke_pkt;

   typedef struct packed {
      logic              valid;
      logic [`PRF_W-1:0] prfid;
   } t_rat_reclaim_pkt;

   typedef struct packed {
      logic              valid;
      logic [`GPR_W-1:0] gpr;
      logic [`PRF_W-1:0] prfid;
   } t_rat_restore_pkt;

   typedef struct packed {
      logic    valid;
      t_rob_id robid;
      t_uinstr uinstr;
   } t_retire_pkt;

   // Full robid of a slot that lies between head and tail.
   // Slots below the head index were allocated after the tail wrapped
   function automatic t_rob_id f_robid_of_idx(t_rob_id head, logic [`ROB_IDX_W-1:0] idx);
      t_rob_id id;
      id.idx  = idx;
      id.wrap = (idx < head.idx) ? ~head.wrap : head.wrap;
      return id;
   endfunction

endpackage

`default_nettype wire

// ==== rob/rat_restore_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rat_restore_walker (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      nuke,
   input  rob_pkg::t_rob_id          head_id,
   input  rob_pkg::t_rob_id          tail_id,
   input  rob_pkg::t_rob_ent         entries [`ROB_NUM_ENTS-1:0],
   output logic                      busy,
   output rob_pkg::t_rat_restore_pkt restore,
   output logic                      resume_fetch
);
   import rob_pkg::*;

   localparam int QCNT_W = $clog2(`ROB_QUIESCE_CYCLES + 1);

   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_rr_state;

   t_rr_state         state;
   logic [QCNT_W-1:0] qcnt;
   t_rob_id           walk_ptr;
   t_rob_id           walk_id;
   t_rob_ent          walk_ent;

   // Pointer holds one past the entry being restored
   assign walk_id  = t_rob_id'(walk_ptr - 1'b1);
   assign walk_ent = entries[walk_id.idx];

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= RR_IDLE;
         qcnt     <= '0;
         walk_ptr <= '0;
      end else begin
         case (state)
            RR_IDLE: begin
               if (nuke) begin
                  state    <= RR_QUIET;
                  qcnt     <= QCNT_W'(`ROB_QUIESCE_CYCLES - 1);
                  walk_ptr <= tail_id;
               end
            end
            RR_QUIET: begin
               if (qcnt == '0) begin
                  state <= RR_WALK;
               end else begin
                  qcnt <= qcnt - 1'b1;
               end
            end
            RR_WALK: begin
               walk_ptr <= walk_id;
               // Head is the last entry to restore
               if (walk_id == head_id) begin
                  state <= RR_RESUME;
               end
            end
            RR_RESUME: begin
               state <= RR_IDLE;
            end
            default: begin
               state <= RR_IDLE;
            end
         endcase
      end
   end

   assign busy         = (state != RR_IDLE);
   assign resume_fetch = (state == RR_RESUME);

   always_comb begin
      restore.valid = (state == RR_WALK) & walk_ent.st.uinstr.dst_valid;
      restore.gpr   = walk_ent.st.uinstr.dst_reg;
      restore.prfid = walk_ent.st.pdst_old;
   end

endmodule

`default_nettype wire

// ==== rob/rob_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_core (
   input  logic                       clk,
   input  logic                       reset,

   output logic                       rob_ready,
   output rob_pkg::t_rob_id           next_robid,
   output rob_pkg::t_rob_id           oldest_robid,

   input  logic                       alloc,
   input  rob_pkg::t_uinstr           alloc_uinstr,
   input  logic [`PRF_W-1:0]          pdst_old,

   input  rob_pkg::t_rob_complete_pkt ex_complete,
   input  rob_pkg::t_rob_complete_pkt mm_complete,

   input  logic [`GPR_W-1:0]          src_addr    [`ROB_NUM_SRCS-1:0],
   output logic                       src_pending [`ROB_NUM_SRCS-1:0],
   output rob_pkg::t_rob_id           src_robid   [`ROB_NUM_SRCS-1:0],

   output rob_pkg::t_retire_pkt       retire,
   output rob_pkg::t_rat_reclaim_pkt  reclaim,
   output rob_pkg::t_nuke_pkt         nuke,
   output rob_pkg::t_rat_restore_pkt  restore,
   output logic                       resume_fetch
);
   import rob_pkg::*;

   t_rob_id                  head_id;
   t_rob_id                  tail_id;
   t_rob_ent                 entries [`ROB_NUM_ENTS-1:0];
   t_rob_ent                 head_ent;
   t_rob_ent_static          new_st;
   logic [`ROB_NUM_ENTS-1:0] e_alloc;
   logic [`ROB_NUM_ENTS-1:0] e_retire;
   logic                     rob_full;
   logic                     rob_empty;
   logic                     q_alloc;
   logic                     q_retire;
   logic                     q_nuke;
   logic                     walk_busy;

   assign rob_empty = (head_id == tail_id);
   assign rob_full  = (head_id.idx == tail_id.idx) & (head_id.wrap != tail_id.wrap);

   // No new ops from the nuke cycle until fetch resumes
   assign rob_ready = ~rob_full & ~walk_busy & ~q_nuke;
   assign q_alloc   = alloc & rob_ready;

   assign head_ent = entries[head_id.idx];

   // A flagged head nukes instead of retiring
   assign q_retire = ~rob_empty & head_ent.valid & head_ent.ready & ~head_ent.flush_needed;
   assign q_nuke   = ~rob_empty & head_ent.valid & head_ent.ready & head_ent.flush_needed;

   always_ff @(posedge clk) begin
      if (reset) begin
         head_id <= '0;
         tail_id <= '0;
      end else begin
         if (q_retire) begin
            head_id <= t_rob_id'(head_id + 1'b1);
         end
         if (q_nuke) begin
            tail_id <= head_id;
         end else if (q_alloc) begin
            tail_id <= t_rob_id'(tail_id + 1'b1);
         end
      end
   end

   assign next_robid   = tail_id;
   assign oldest_robid = head_id;

   always_comb begin
      retire.valid     = q_retire;
      retire.robid     = head_id;
      retire.uinstr    = head_ent.st.uinstr;
      reclaim.valid    = q_retire & head_ent.st.uinstr.dst_valid;
      reclaim.prfid    = head_ent.st.pdst_old;
      nuke.valid       = q_nuke;
      nuke.nuke_type   = head_ent.mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION;
      new_st.uinstr    = alloc_uinstr;
      new_st.pdst_old  = pdst_old;
   end

   for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_ents
      t_rob_id slot_robid;

      assign slot_robid  = f_robid_of_idx(head_id, `ROB_IDX_W'(i));
      assign e_alloc[i]  = q_alloc & (tail_id.idx == `ROB_IDX_W'(i));
      assign e_retire[i] = q_retire & (head_id.idx == `ROB_IDX_W'(i));

      rob_entry u_entry (
         .clk         (clk),
         .reset       (reset),
         .alloc       (e_alloc[i]),
         .alloc_data  (new_st),
         .robid       (slot_robid),
         .ex_complete (ex_complete),
         .mm_complete (mm_complete),
         .flush       (q_nuke),
         .retire      (e_retire[i]),
         .entry       (entries[i])
      );
   end

   rob_src_lookup u_src_lookup (
      .entries     (entries),
      .head_id     (head_id),
      .tail_id     (tail_id),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid)
   );

   // Walker samples the pre-nuke tail at the nuke edge
   rat_restore_walker u_walker (
      .clk          (clk),
      .reset        (reset),
      .nuke         (q_nuke),
      .head_id      (head_id),
      .tail_id      (tail_id),
      .entries      (entries),
      .busy         (walk_busy),
      .restore      (restore),
      .resume_fetch (resume_fetch)
   );

endmodule

`default_nettype wire

// ==== rob/rob_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_entry (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       alloc,
   input  rob_pkg::t_rob_ent_static   alloc_data,
   input  rob_pkg::t_rob_id           robid,
   input  rob_pkg::t_rob_complete_pkt ex_complete,
   input  rob_pkg::t_rob_complete_pkt mm_complete,
   input  logic                       flush,
   input  logic                       retire,
   output rob_pkg::t_rob_ent          entry
);
   import rob_pkg::*;

   logic            ent_valid;
   logic            ent_ready;
   logic            ent_flush;
   logic            ent_mispred;
   t_rob_ent_static ent_st;
   logic            ex_hit;
   logic            mm_hit;

   // Wrap bit takes part in the compare so a stale id cannot complete a new op
   assign ex_hit = ent_valid & ex_complete.valid & (ex_complete.robid == robid);
   assign mm_hit = ent_valid & mm_complete.valid & (mm_complete.robid == robid);

   always_ff @(posedge clk) begin
      if (reset) begin
         ent_valid   <= 1'b0;
         ent_ready   <= 1'b0;
         ent_flush   <= 1'b0;
         ent_mispred <= 1'b0;
      end else if (alloc) begin
         ent_valid   <= 1'b1;
         ent_ready   <= 1'b0;
         ent_flush   <= 1'b0;
         ent_mispred <= 1'b0;
      end else if (retire | flush) begin
         ent_valid <= 1'b0;
      end else if (ex_hit | mm_hit) begin
         ent_ready   <= 1'b1;
         ent_flush   <= ent_flush | (ex_hit & ex_complete.flush_needed)
                                  | (mm_hit & mm_complete.flush_needed);
         ent_mispred <= ent_mispred | (ex_hit & ex_complete.mispred)
                                    | (mm_hit & mm_complete.mispred);
      end
   end

   // Static data survives a flush, the restore walk reads it afterwards
   always_ff @(posedge clk) begin
      if (alloc) begin
         ent_st <= alloc_data;
      end
   end

   always_comb begin
      entry.valid        = ent_valid;
      entry.ready        = ent_ready;
      entry.flush_needed = ent_flush;
      entry.mispred      = ent_mispred;
      entry.st           = ent_st;
   end

endmodule

`default_nettype wire

// ==== rob/rob_src_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_src_lookup (
   input  rob_pkg::t_rob_ent entries     [`ROB_NUM_ENTS-1:0],
   input  rob_pkg::t_rob_id  head_id,
   input  rob_pkg::t_rob_id  tail_id,
   input  logic [`GPR_W-1:0] src_addr    [`ROB_NUM_SRCS-1:0],
   output logic              src_pending [`ROB_NUM_SRCS-1:0],
   output rob_pkg::t_rob_id  src_robid   [`ROB_NUM_SRCS-1:0]
);
   import rob_pkg::*;

   for (genvar s = 0; s < `ROB_NUM_SRCS; s++) begin : g_src
      logic [`ROB_NUM_ENTS-1:0] match;

      for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_match
         assign match[i] = entries[i].valid
                         & entries[i].st.uinstr.dst_valid
                         & (entries[i].st.uinstr.dst_reg == src_addr[s]);
      end

      // Scan from the oldest position towards tail minus one, later hits
      // overwrite earlier ones so the youngest writer wins
      always_comb begin
         logic [`ROB_IDX_W-1:0] scan_idx;
         logic [`ROB_IDX_W-1:0] hit_idx;
         hit_idx = '0;
         for (int k = `ROB_NUM_ENTS; k >= 1; k--) begin
            scan_idx = tail_id.idx - `ROB_IDX_W'(k);
            if (match[scan_idx]) begin
               hit_idx = scan_idx;
            end
         end
         src_pending[s] = |match;
         src_robid[s]   = f_robid_of_idx(head_id, hit_idx);
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module rob_tb \
   --Mdir obj_dir -o rob_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/rob_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^No errors$" "$LOG"; then
   exit 0
fi
echo "Simulation reported a failure, see $LOG"
exit 1

// ==== sources.f ====
+incdir+common
common/rob_pkg.sv
rob/rob_entry.sv
rob/rob_src_lookup.sv
rob/rat_restore_walker.sv
rob/rob_core.sv
verif/rob_tb.sv

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_tb;
   import rob_pkg::*;

   localparam int TIMEOUT = 200;

   // Reference view of one in-flight micro-op
   typedef struct packed {
      t_rob_id           robid;
      t_uinstr           u;
      logic [`PRF_W-1:0] pdst;
      logic              done;
      logic              flush;
      logic              mispred;
   } t_ref_op;

   logic                     clk;
   logic                     reset;
   logic                     rob_ready;
   t_rob_id                  next_robid;
   t_rob_id                  oldest_robid;
   logic                     alloc;
   t_uinstr                  alloc_uinstr;
   logic [`PRF_W-1:0]        pdst_old;
   t_rob_complete_pkt        ex_complete;
   t_rob_complete_pkt        mm_complete;
   logic [`GPR_W-1:0]        src_addr    [`ROB_NUM_SRCS-1:0];
   logic                     src_pending [`ROB_NUM_SRCS-1:0];
   t_rob_id                  src_robid   [`ROB_NUM_SRCS-1:0];
   t_retire_pkt              retire;
   t_rat_reclaim_pkt         reclaim;
   t_nuke_pkt                nuke;
   t_rat_restore_pkt         restore;
   logic                     resume_fetch;

   t_ref_op                  ref_q [$];
   logic [`GPR_W+`PRF_W:0]   exp_rst [$];
   t_rob_id                  head_ref;
   t_rob_id                  tail_ref;
   logic                     walking;
   int                       walk_cyc;
   int                       walk_len;
   logic [31:0]              seed;
   logic [7:0]               tag_cnt;
   int                       errors;
   int                       checks;
   int                       nukes;
   int                       resumes;

   rob_core uut (
      .clk          (clk),
      .reset        (reset),
      .rob_ready    (rob_ready),
      .next_robid   (next_robid),
      .oldest_robid (oldest_robid),
      .alloc        (alloc),
      .alloc_uinstr (alloc_uinstr),
      .pdst_old     (pdst_old),
      .ex_complete  (ex_complete),
      .mm_complete  (mm_complete),
      .src_addr     (src_addr),
      .src_pending  (src_pending),
      .src_robid    (src_robid),
      .retire       (retire),
      .reclaim      (reclaim),
      .nuke         (nuke),
      .restore      (restore),
      .resume_fetch (resume_fetch)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic int rand_below(input int n);
      return int'((lcg_next() >> 8) % 32'(n));
   endfunction

   // Youngest in-flight writer of a register with the pending bit on top
   function automatic logic [`ROB_IDX_W+1:0] youngest_producer(input logic [`GPR_W-1:0] gpr);
      logic [`ROB_IDX_W+1:0] res;
      res = '0;
      foreach (ref_q[i]) begin
         if (ref_q[i].u.dst_valid && ref_q[i].u.dst_reg == gpr) begin
            res = {1'b1, ref_q[i].robid};
         end
      end
      return res;
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic finish_run();
      $display("checks: %0d, errors: %0d, nukes: %0d, resumes: %0d",
               checks, errors, nukes, resumes);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   endtask

   task automatic mark_complete(input t_rob_complete_pkt pkt);
      t_ref_op tmp;
      foreach (ref_q[i]) begin
         if (pkt.valid && ref_q[i].robid == pkt.robid) begin
            tmp         = ref_q[i];
            tmp.done    = 1'b1;
            tmp.flush   = tmp.flush | pkt.flush_needed;
            tmp.mispred = tmp.mispred | pkt.mispred;
            ref_q[i]    = tmp;
         end
      end
   endtask

   // Compare every output in the middle of the cycle, then record what
   // the DUT takes at the next rising edge
   always @(negedge clk) begin
      logic                  exp_ret;
      logic                  exp_nuke;
      logic                  exp_ready;
      logic                  exp_resume;
      logic [`ROB_IDX_W+1:0] exp_src;
      logic [`GPR_W+`PRF_W:0] rst;
      if (!reset) begin
         if (walking) begin
            walk_cyc++;
         end
         if (nuke.valid) begin
            nukes++;
         end
         if (resume_fetch) begin
            resumes++;
         end
         exp_ret   = (ref_q.size() > 0) && ref_q[0].done && !ref_q[0].flush;
         exp_nuke  = (ref_q.size() > 0) && ref_q[0].done && ref_q[0].flush;
         exp_ready = (ref_q.size() < `ROB_NUM_ENTS) && !walking && !exp_nuke;
         check("rob_ready", rob_ready, exp_ready);
         check("next_robid", next_robid, tail_ref);
         check("oldest_robid", oldest_robid, head_ref);
         check("retire.valid", retire.valid, exp_ret);
         check("nuke.valid", nuke.valid, exp_nuke);
         for (int s = 0; s < `ROB_NUM_SRCS; s++) begin
            exp_src = youngest_producer(src_addr[s]);
            check("src_pending", src_pending[s], exp_src[`ROB_IDX_W+1]);
            if (exp_src[`ROB_IDX_W+1]) begin
               check("src_robid", src_robid[s], exp_src[`ROB_IDX_W:0]);
            end
         end
         if (exp_ret) begin
            check("retire.robid", retire.robid, ref_q[0].robid);
            check("retire.uinstr", retire.uinstr, ref_q[0].u);
            check("reclaim.valid", reclaim.valid, ref_q[0].u.dst_valid);
            if (ref_q[0].u.dst_valid) begin
               check("reclaim.prfid", reclaim.prfid, ref_q[0].pdst);
            end
            void'(ref_q.pop_front());
            head_ref = t_rob_id'(head_ref + 4'd1);
         end else begin
            check("reclaim.valid", reclaim.valid, 1'b0);
         end
         if (exp_nuke) begin
            check("nuke_type", nuke.nuke_type,
                  ref_q[0].mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION);
            // Walk order runs from the youngest op down to the head
            for (int i = ref_q.size() - 1; i >= 0; i--) begin
               exp_rst.push_back({ref_q[i].u.dst_valid, ref_q[i].u.dst_reg, ref_q[i].pdst});
            end
            walk_len = ref_q.size();
            walk_cyc = 0;
            ref_q.delete();
            tail_ref = head_ref;
            walking  = 1'b1;
         end
         // One walk step per cycle once the quiet time has passed
         if (walking && walk_cyc > `ROB_QUIESCE_CYCLES && exp_rst.size() != 0) begin
            rst = exp_rst.pop_front();
            check("restore.valid", restore.valid, rst[`GPR_W+`PRF_W]);
            if (rst[`GPR_W+`PRF_W]) begin
               check("restore.gpr", restore.gpr, rst[`GPR_W+`PRF_W-1:`PRF_W]);
               check("restore.prfid", restore.prfid, rst[`PRF_W-1:0]);
            end
         end else begin
            check("restore.valid", restore.valid, 1'b0);
         end
         exp_resume = walking && (walk_cyc == `ROB_QUIESCE_CYCLES + walk_len + 1);
         check("resume_fetch", resume_fetch, exp_resume);
         if (exp_resume) begin
            walking = 1'b0;
         end
         if (alloc && exp_ready) begin
            ref_q.push_back({tail_ref, alloc_uinstr, pdst_old, 3'b000});
            tail_ref = t_rob_id'(tail_ref + 4'd1);
         end
         mark_complete(ex_complete);
         mark_complete(mm_complete);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;
      alloc       = 1'b0;
      ex_complete = '0;
      mm_complete = '0;
   endtask

   task automatic load_uop(input logic dst_valid, input logic [`GPR_W-1:0] dst_reg);
      alloc_uinstr.dst_valid = dst_valid;
      alloc_uinstr.dst_reg   = dst_reg;
      alloc_uinstr.is_branch = rand_below(2) == 1;
      alloc_uinstr.tag       = tag_cnt;
      pdst_old               = `PRF_W'(rand_below(64));
      tag_cnt++;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!rob_ready && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (!rob_ready) begin
         $display("Timeout: rob_ready stayed low for %0d cycles", TIMEOUT);
         errors++;
         finish_run();
      end
   endtask

   task automatic alloc_op(input logic dst_valid, input logic [`GPR_W-1:0] dst_reg);
      wait_ready();
      alloc = 1'b1;
      load_uop(dst_valid, dst_reg);
      next_cycle();
   endtask

   // Complete up to two different open ops, one per port
   task automatic drive_completions(input int pct, input logic skip_head);
      int open [$];
      int a;
      foreach (ref_q[i]) begin
         if (!ref_q[i].done && !(skip_head && i == 0)) begin
            open.push_back(i);
         end
      end
      if (open.size() > 0 && rand_below(100) < pct) begin
         a = rand_below(open.size());
         ex_complete.valid = 1'b1;
         ex_complete.robid = ref_q[open[a]].robid;
         open.delete(a);
      end
      if (open.size() > 0 && rand_below(100) < pct) begin
         a = rand_below(open.size());
         mm_complete.valid = 1'b1;
         mm_complete.robid = ref_q[open[a]].robid;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (ref_q.size() != 0 && n < TIMEOUT) begin
         drive_completions(60, 1'b0);
         next_cycle();
         n++;
      end
      if (ref_q.size() != 0) begin
         $display("Timeout: buffer did not drain within %0d cycles", TIMEOUT);
         errors++;
         finish_run();
      end
   endtask

   task automatic flush_test(input logic mispred, input int n_ops);
      int n;
      int start;
      for (int i = 0; i < n_ops; i++) begin
         alloc_op(rand_below(4) != 0, `GPR_W'(rand_below(8)));
      end
      for (int i = 0; i < 4; i++) begin
         drive_completions(70, 1'b1);
         next_cycle();
      end
      // Mispredicts flag the oldest op through the execute port and exceptions through memory
      if (mispred) begin
         ex_complete = '{valid: 1'b1, robid: ref_q[0].robid, flush_needed: 1'b1, mispred: 1'b1};
      end else begin
         mm_complete = '{valid: 1'b1, robid: ref_q[0].robid, flush_needed: 1'b1, mispred: 1'b0};
      end
      start = resumes;
      n     = 0;
      next_cycle();
      while (resumes == start && n < TIMEOUT) begin
         next_cycle();
         n++;
      end
      if (resumes == start) begin
         $display("Timeout: no resume_fetch within %0d cycles of the flush", TIMEOUT);
         errors++;
         finish_run();
      end
      check("next_robid after resume", next_robid, head_ref);
      check("oldest_robid after resume", oldest_robid, head_ref);
   endtask

   initial begin
      t_rob_id saved;
      int      n;
      seed         = 32'h63d1_ae79;
      errors       = 0;
      checks       = 0;
      nukes        = 0;
      resumes      = 0;
      tag_cnt      = '0;
      head_ref     = '0;
      tail_ref     = '0;
      walking      = 1'b0;
      walk_cyc     = 0;
      walk_len     = 0;
      reset        = 1'b1;
      alloc        = 1'b0;
      alloc_uinstr = '0;
      pdst_old     = '0;
      ex_complete  = '0;
      mm_complete  = '0;
      for (int s = 0; s < `ROB_NUM_SRCS; s++) begin
         src_addr[s] = '0;
      end
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;
      repeat (3) next_cycle();
      check("next_robid after reset", next_robid, 0);

      // Random traffic whose allocation attempts also come while rob_ready is low
      for (int c = 0; c < 300; c++) begin
         alloc = rand_below(2) == 1;
         load_uop(rand_below(3) != 0, `GPR_W'(rand_below(8)));
         src_addr[0] = `GPR_W'(rand_below(8));
         src_addr[1] = `GPR_W'(rand_below(8));
         drive_completions(40, 1'b0);
         next_cycle();
      end
      wait_drain();

      // Fill the buffer, then try one more
      for (int i = 0; i < `ROB_NUM_ENTS; i++) begin
         alloc_op(1'b1, `GPR_W'(i));
      end
      check("rob_ready when full", rob_ready, 1'b0);
      saved = next_robid;
      alloc = 1'b1;
      load_uop(1'b1, 5'd3);
      next_cycle();
      check("next_robid after refused alloc", next_robid, saved);
      ex_complete.valid = 1'b1;
      ex_complete.robid = ref_q[0].robid;
      next_cycle();
      wait_ready();
      wait_drain();

      // Writers of r9 that straddle the index wraparound
      src_addr[0] = 5'd9;
      src_addr[1] = 5'd10;
      n = 0;
      while (tail_ref.idx != 3'd6 && n < `ROB_NUM_ENTS) begin
         alloc_op(1'b0, 5'd0);
         n++;
      end
      wait_drain();
      alloc_op(1'b1, 5'd9);
      alloc_op(1'b1, 5'd10);
      alloc_op(1'b1, 5'd9);
      alloc_op(1'b0, 5'd9);
      alloc_op(1'b1, 5'd9);
      check("r9 pending", src_pending[0], 1'b1);
      check("youngest writer of r9", src_robid[0], t_rob_id'(tail_ref - 4'd1));
      wait_drain();

      flush_test(1'b1, 6);
      flush_test(1'b0, 5);
      check("nuke count", nukes, 2);
      check("resume count", resumes, 2);
      finish_run();
   end

endmodule

`default_nettype wire
